//--- logic/memcopy_pkg.sv
/*
 * Memory-copy engine package
 * Widths, depths, latencies and register indices
 */
package memcopy_pkg;

  localparam int DATA_W      = 32;
  localparam int MEM_WORDS   = 128;
  localparam int ADDR_W      = 7;

  // Buffer depth doubles as the reader's starting credit count
  localparam int FIFO_DEPTH  = 4;
  localparam int CRED_W      = 3;

  // Grant to rvalid, in cycles
  localparam int MEM_LATENCY = 2;

  localparam int LEN_W       = 8;

  // Register bus, word-indexed
  localparam int REG_ADDR_W  = 3;
  localparam logic [REG_ADDR_W-1:0] REG_SRC    = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_DST    = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_LEN    = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd4;

  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

endpackage

//--- logic/memcopy_regs.sv
/*
 * Memory-copy register slave
 * Holds the copy configuration, busy and done flags, and the done interrupt
 */
`timescale 1ns/1ps

module memcopy_regs
  import memcopy_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0]     reg_wdata_i,
  input  logic                  copy_done_i,
  output logic [DATA_W-1:0]     reg_rdata_o,
  output logic                  start_o,
  output logic [ADDR_W-1:0]     src_addr_o,
  output logic [ADDR_W-1:0]     dst_addr_o,
  output logic [LEN_W-1:0]      len_o,
  output logic                  done_intr_o
);

  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [LEN_W-1:0]  len_q;
  logic              busy_q;
  logic              done_q;
  logic              wr_en;
  logic              status_rd;

  assign wr_en     = reg_valid_i && reg_write_i;
  assign status_rd = reg_valid_i && !reg_write_i && (reg_addr_i == REG_STATUS);

  // Start is dropped while a copy is running
  assign start_o = wr_en && (reg_addr_i == REG_CTRL) && reg_wdata_i[0] && !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      len_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (wr_en && reg_addr_i == REG_SRC) src_q <= reg_wdata_i[ADDR_W-1:0];
      if (wr_en && reg_addr_i == REG_DST) dst_q <= reg_wdata_i[ADDR_W-1:0];
      if (wr_en && reg_addr_i == REG_LEN) len_q <= reg_wdata_i[LEN_W-1:0];

      if (start_o) begin
        busy_q <= 1'b1;
      end else if (copy_done_i) begin
        busy_q <= 1'b0;
      end

      // A completing copy wins over a clearing status read
      if (copy_done_i) begin
        done_q <= 1'b1;
      end else if (start_o || status_rd) begin
        done_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      REG_SRC:    reg_rdata_o[ADDR_W-1:0] = src_q;
      REG_DST:    reg_rdata_o[ADDR_W-1:0] = dst_q;
      REG_LEN:    reg_rdata_o[LEN_W-1:0]  = len_q;
      REG_STATUS: begin
        reg_rdata_o[STATUS_BUSY_BIT] = busy_q;
        reg_rdata_o[STATUS_DONE_BIT] = done_q;
      end
      default:    reg_rdata_o = '0;
    endcase
  end

  assign src_addr_o  = src_q;
  assign dst_addr_o  = dst_q;
  assign len_o       = len_q;
  assign done_intr_o = done_q;

endmodule

//--- logic/memcopy_reader.sv
/*
 * Memory-copy reader
 * Issues source reads against credits and pushes returned words to the buffer
 */
`timescale 1ns/1ps

module memcopy_reader
  import memcopy_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] src_addr_i,
  input  logic [LEN_W-1:0]  len_i,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic              credit_return_i,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic              push_valid_o,
  output logic [DATA_W-1:0] push_data_o
);

  logic              active_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  issued_q;
  logic [CRED_W-1:0] credits_q;
  logic              rd_fire;

  assign mem_req_o  = active_q && (credits_q != '0);
  assign mem_addr_o = addr_q;
  assign rd_fire    = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      addr_q   <= '0;
      len_q    <= '0;
      issued_q <= '0;
    end else if (start_i) begin
      active_q <= (len_i != '0);
      addr_q   <= src_addr_i;
      len_q    <= len_i;
      issued_q <= '0;
    end else if (rd_fire) begin
      addr_q   <= addr_q + 1'b1;
      issued_q <= issued_q + 1'b1;
      // Stop once the last read is granted
      if (issued_q == len_q - LEN_W'(1)) active_q <= 1'b0;
    end
  end

  // One credit per granted read, one back per pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= CRED_W'(FIFO_DEPTH);
    end else begin
      credits_q <= credits_q - CRED_W'(rd_fire) + CRED_W'(credit_return_i);
    end
  end

  // Returned words go straight to the buffer, space is already reserved
  assign push_valid_o = mem_rvalid_i;
  assign push_data_o  = mem_rdata_i;

endmodule

//--- logic/credit_fifo.sv
/*
 * Credit FIFO
 * Circular buffer between reader and writer, returns one credit per pop
 */
`timescale 1ns/1ps

module credit_fifo
  import memcopy_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              push_valid_i,
  input  logic [DATA_W-1:0] push_data_i,
  input  logic              pop_ready_i,
  output logic              pop_valid_o,
  output logic [DATA_W-1:0] pop_data_o,
  output logic              credit_return_o
);

  logic [DATA_W-1:0]              mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr_q;
  logic [CRED_W-1:0]              count_q;
  logic                           credit_q;
  logic                           pop;

  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];
  assign pop         = pop_valid_o && pop_ready_i;

  // Storage, no reset needed
  always_ff @(posedge clk_i) begin
    if (push_valid_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (push_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q  <= count_q + CRED_W'(push_valid_i) - CRED_W'(pop);
      credit_q <= pop;
    end
  end

  assign credit_return_o = credit_q;

endmodule

//--- logic/memcopy_writer.sv
/*
 * Memory-copy writer
 * Pops buffered words and stores them at ascending destination addresses
 */
`timescale 1ns/1ps

module memcopy_writer
  import memcopy_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] dst_addr_i,
  input  logic [LEN_W-1:0]  len_i,
  input  logic              pop_valid_i,
  input  logic [DATA_W-1:0] pop_data_i,
  input  logic              mem_gnt_i,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  output logic              pop_ready_o,
  output logic              copy_done_o
);

  logic              active_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  cnt_q;
  logic              last_word;

  assign mem_req_o   = active_q && pop_valid_i;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = pop_data_i;
  assign pop_ready_o = mem_req_o && mem_gnt_i;

  assign last_word = (cnt_q == len_q - LEN_W'(1));

  // Zero length completes the cycle after start
  assign copy_done_o = active_q && ((len_q == '0) || (pop_ready_o && last_word));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      addr_q   <= '0;
      len_q    <= '0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      addr_q   <= dst_addr_i;
      len_q    <= len_i;
      cnt_q    <= '0;
    end else begin
      if (pop_ready_o) begin
        addr_q <= addr_q + 1'b1;
        cnt_q  <= cnt_q + 1'b1;
      end
      if (copy_done_o) active_q <= 1'b0;
    end
  end

endmodule

//--- logic/slow_memory.sv
/*
 * Slow external RAM
 * Three-port fixed-priority arbiter with a pipelined fixed read latency
 */
`timescale 1ns/1ps

module slow_memory
  import memcopy_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              host_req_i,
  input  logic              host_we_i,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic [DATA_W-1:0] host_wdata_i,
  output logic              host_gnt_o,
  output logic              host_rvalid_o,
  output logic [DATA_W-1:0] host_rdata_o,
  input  logic              wr_req_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_wdata_i,
  output logic              wr_gnt_o,
  input  logic              rd_req_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic              rd_gnt_o,
  output logic              rd_rvalid_o,
  output logic [DATA_W-1:0] rd_rdata_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  // Read return pipeline, tag is high for host reads
  logic              pipe_valid_q [MEM_LATENCY];
  logic              pipe_host_q  [MEM_LATENCY];
  logic [DATA_W-1:0] pipe_data_q  [MEM_LATENCY];

  logic              acc_we;
  logic [ADDR_W-1:0] acc_addr;
  logic [DATA_W-1:0] acc_wdata;
  logic              rd_issue;

  // Host first, then writer, then reader
  assign host_gnt_o = host_req_i;
  assign wr_gnt_o   = wr_req_i && !host_req_i;
  assign rd_gnt_o   = rd_req_i && !host_req_i && !wr_req_i;

  always_comb begin
    acc_we    = 1'b0;
    acc_addr  = rd_addr_i;
    acc_wdata = host_wdata_i;
    if (host_req_i) begin
      acc_we   = host_we_i;
      acc_addr = host_addr_i;
    end else if (wr_req_i) begin
      acc_we    = 1'b1;
      acc_addr  = wr_addr_i;
      acc_wdata = wr_wdata_i;
    end
  end

  assign rd_issue = (host_gnt_o && !host_we_i) || rd_gnt_o;

  always_ff @(posedge clk_i) begin
    if ((host_gnt_o || wr_gnt_o) && acc_we) mem_q[acc_addr] <= acc_wdata;
    pipe_host_q[0] <= host_gnt_o;
    pipe_data_q[0] <= mem_q[acc_addr];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      pipe_host_q[i] <= pipe_host_q[i-1];
      pipe_data_q[i] <= pipe_data_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_LATENCY; i++) pipe_valid_q[i] <= 1'b0;
    end else begin
      pipe_valid_q[0] <= rd_issue;
      for (int i = 1; i < MEM_LATENCY; i++) pipe_valid_q[i] <= pipe_valid_q[i-1];
    end
  end

  assign host_rvalid_o = pipe_valid_q[MEM_LATENCY-1] && pipe_host_q[MEM_LATENCY-1];
  assign rd_rvalid_o   = pipe_valid_q[MEM_LATENCY-1] && !pipe_host_q[MEM_LATENCY-1];
  assign host_rdata_o  = pipe_data_q[MEM_LATENCY-1];
  assign rd_rdata_o    = pipe_data_q[MEM_LATENCY-1];

endmodule

//--- logic/testharness_ext.sv
/*
 * External peripheral harness
 * Register block, memory-copy engine and slow RAM with a host port
 */
`timescale 1ns/1ps

module testharness_ext
  import memcopy_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0]     reg_wdata_i,
  output logic [DATA_W-1:0]     reg_rdata_o,
  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  logic [ADDR_W-1:0]     host_addr_i,
  input  logic [DATA_W-1:0]     host_wdata_i,
  output logic                  host_gnt_o,
  output logic                  host_rvalid_o,
  output logic [DATA_W-1:0]     host_rdata_o,
  output logic                  done_intr_o
);

  // Engine control
  logic              start;
  logic [ADDR_W-1:0] src_addr;
  logic [ADDR_W-1:0] dst_addr;
  logic [LEN_W-1:0]  len;
  logic              copy_done;

  // Reader and writer memory ports
  logic              rd_req;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_gnt;
  logic              rd_rvalid;
  logic [DATA_W-1:0] rd_rdata;
  logic              wr_req;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_wdata;
  logic              wr_gnt;

  // Buffer links
  logic              push_valid;
  logic [DATA_W-1:0] push_data;
  logic              pop_valid;
  logic [DATA_W-1:0] pop_data;
  logic              pop_ready;
  logic              credit_return;

  memcopy_regs regs_i (
    .clk_i, .rst_n_i, .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .copy_done_i(copy_done), .reg_rdata_o, .start_o(start), .src_addr_o(src_addr),
    .dst_addr_o(dst_addr), .len_o(len), .done_intr_o
  );

  memcopy_reader reader_i (
    .clk_i, .rst_n_i, .start_i(start), .src_addr_i(src_addr), .len_i(len),
    .mem_gnt_i(rd_gnt), .mem_rvalid_i(rd_rvalid), .mem_rdata_i(rd_rdata),
    .credit_return_i(credit_return), .mem_req_o(rd_req), .mem_addr_o(rd_addr),
    .push_valid_o(push_valid), .push_data_o(push_data)
  );

  credit_fifo fifo_i (
    .clk_i, .rst_n_i, .push_valid_i(push_valid), .push_data_i(push_data),
    .pop_ready_i(pop_ready), .pop_valid_o(pop_valid), .pop_data_o(pop_data),
    .credit_return_o(credit_return)
  );

  memcopy_writer writer_i (
    .clk_i, .rst_n_i, .start_i(start), .dst_addr_i(dst_addr), .len_i(len),
    .pop_valid_i(pop_valid), .pop_data_i(pop_data), .mem_gnt_i(wr_gnt),
    .mem_req_o(wr_req), .mem_addr_o(wr_addr), .mem_wdata_o(wr_wdata),
    .pop_ready_o(pop_ready), .copy_done_o(copy_done)
  );

  slow_memory slow_ram_i (
    .clk_i, .rst_n_i, .host_req_i, .host_we_i, .host_addr_i, .host_wdata_i,
    .host_gnt_o, .host_rvalid_o, .host_rdata_o,
    .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_wdata_i(wr_wdata), .wr_gnt_o(wr_gnt),
    .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(rd_gnt),
    .rd_rvalid_o(rd_rvalid), .rd_rdata_o(rd_rdata)
  );

endmodule

//--- sim/testharness_ext_asserts.sv
/*
 * Protocol assertions for the external peripheral harness
 */
`timescale 1ns/1ps

module testharness_ext_asserts
  import memcopy_pkg::*;
(
  input logic clk_i,
  input logic rst_n_i,
  input logic host_we_i,
  input logic host_gnt_i,
  input logic host_rvalid_i,
  input logic wr_gnt_i,
  input logic rd_gnt_i,
  input logic push_valid_i,
  input logic pop_ready_i,
  input logic credit_return_i,
  input logic copy_done_i,
  input logic done_intr_i
);

  int unsigned fail_count = 0;
  int          occupancy;
  int          credits;

  // Reference counts of buffered words and reader credits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      occupancy <= 0;
      credits   <= FIFO_DEPTH;
    end else begin
      occupancy <= occupancy + int'(push_valid_i) - int'(pop_ready_i);
      credits   <= credits - int'(rd_gnt_i) + int'(credit_return_i);
    end
  end

  one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({host_gnt_i, wr_gnt_i, rd_gnt_i}))
    else begin
      $error("more than one memory grant in one cycle");
      fail_count++;
    end

  host_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_i == $past(host_gnt_i && !host_we_i, MEM_LATENCY))
    else begin
      $error("host rvalid not exactly MEM_LATENCY cycles after a host read grant");
      fail_count++;
    end

  fifo_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    occupancy <= FIFO_DEPTH && credits <= FIFO_DEPTH)
    else begin
      $error("buffer occupancy or reader credits above FIFO_DEPTH");
      fail_count++;
    end

  // Interrupt follows the completing write by one edge
  done_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(done_intr_i) |-> $past(copy_done_i))
    else begin
      $error("done interrupt rose without a copy_done in the cycle before");
      fail_count++;
    end

endmodule

bind testharness_ext testharness_ext_asserts asserts_i (
  .clk_i, .rst_n_i, .host_we_i, .host_gnt_i(host_gnt_o), .host_rvalid_i(host_rvalid_o),
  .wr_gnt_i(wr_gnt), .rd_gnt_i(rd_gnt), .push_valid_i(push_valid), .pop_ready_i(pop_ready),
  .credit_return_i(credit_return), .copy_done_i(copy_done), .done_intr_i(done_intr_o)
);

//--- sim/tb_testharness_ext.sv
/*
 * Testbench for the external peripheral harness
 * Register setup, host preload and readback around memory copies
 */
`timescale 1ns/1ps

module tb_testharness_ext
  import memcopy_pkg::*;
();

  localparam int WAIT_LIMIT = 1000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  reg_valid;
  logic                  reg_write;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0]     reg_wdata;
  logic [DATA_W-1:0]     reg_rdata;
  logic                  host_req;
  logic                  host_we;
  logic [ADDR_W-1:0]     host_addr;
  logic [DATA_W-1:0]     host_wdata;
  logic                  host_gnt;
  logic                  host_rvalid;
  logic [DATA_W-1:0]     host_rdata;
  logic                  done_intr;
  logic [DATA_W-1:0]     ref_mem [MEM_WORDS];
  logic [DATA_W-1:0]     rdata;
  int                    seed;
  int                    err_count;
  int                    assert_fails;

  always #10 clk = ~clk;

  testharness_ext UUT (
    .clk_i(clk), .rst_n_i(rst_n), .reg_valid_i(reg_valid), .reg_write_i(reg_write),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_wdata_i(host_wdata), .host_gnt_o(host_gnt), .host_rvalid_o(host_rvalid),
    .host_rdata_o(host_rdata), .done_intr_o(done_intr)
  );

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0d ns while waiting for %s", $time, what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    assert (got == exp) else begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic reg_wr(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  // Read data is combinational, taken well before the clearing edge
  task automatic reg_rd(input logic [REG_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = 1'b0;
    reg_addr  = addr;
    #1;
    data = reg_rdata;
    @(negedge clk);
    reg_valid = 1'b0;
  endtask

  task automatic host_access(input logic we, input int addr, input logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = ADDR_W'(addr);
    host_wdata = data;
    do begin
      @(posedge clk);
      waited++;
    end while (!host_gnt && waited < WAIT_LIMIT);
    if (!host_gnt) begin
      abort_on_timeout("host grant");
    end else begin
      @(negedge clk);
      host_req = 1'b0;
      host_we  = 1'b0;
    end
  endtask

  task automatic host_write(input int addr, input logic [DATA_W-1:0] data);
    host_access(1'b1, addr, data);
    ref_mem[ADDR_W'(addr)] = data;
  endtask

  task automatic host_read(input int addr, output logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    host_access(1'b0, addr, '0);
    do begin
      @(negedge clk);
      waited++;
    end while (!host_rvalid && waited < WAIT_LIMIT);
    if (!host_rvalid) begin
      abort_on_timeout("host read data");
    end else begin
      data = host_rdata;
    end
  endtask

  task automatic start_copy(input int src, input int dst, input int len);
    reg_wr(REG_SRC, DATA_W'(src));
    reg_wr(REG_DST, DATA_W'(dst));
    reg_wr(REG_LEN, DATA_W'(len));
    reg_wr(REG_CTRL, 32'h1);
  endtask

  // Wait for the interrupt, then the status read must show done only
  task automatic finish_copy();
    int waited;
    waited = 0;
    while (!done_intr && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!done_intr) begin
      abort_on_timeout("done interrupt");
    end else begin
      reg_rd(REG_STATUS, rdata);
      check_value("status after copy", rdata, DATA_W'(1) << STATUS_DONE_BIT);
    end
  endtask

  task automatic model_copy(input int src, input int dst, input int len);
    for (int i = 0; i < len; i++) ref_mem[ADDR_W'(dst + i)] = ref_mem[ADDR_W'(src + i)];
  endtask

  task automatic verify_range(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      host_read(base + i, rdata);
      check_value($sformatf("mem[%0d]", base + i), rdata, ref_mem[ADDR_W'(base + i)]);
    end
  endtask

  initial begin
    seed       = 50;
    err_count  = 0;
    rst_n      = 1'b0;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int a = 0; a < MEM_WORDS; a++) host_write(a, $random(seed));

    reg_wr(REG_SRC, 32'h55);
    reg_wr(REG_DST, 32'h2a);
    reg_wr(REG_LEN, 32'hc3);
    reg_rd(REG_SRC, rdata);
    check_value("REG_SRC", rdata, 32'h55);
    reg_rd(REG_DST, rdata);
    check_value("REG_DST", rdata, 32'h2a);
    reg_rd(REG_LEN, rdata);
    check_value("REG_LEN", rdata, 32'hc3);

    start_copy(8, 40, 3);
    finish_copy();
    model_copy(8, 40, 3);
    verify_range(40, 3);

    // Longer than the buffer, so the reader runs out of credits
    start_copy(60, 90, 20);
    reg_rd(REG_STATUS, rdata);
    check_value("status while busy", rdata, DATA_W'(1) << STATUS_BUSY_BIT);
    check_value("done interrupt while busy", DATA_W'(done_intr), '0);
    finish_copy();
    check_value("done interrupt after status read", DATA_W'(done_intr), '0);
    model_copy(60, 90, 20);
    verify_range(90, 21);

    start_copy(0, 112, 16);
    reg_wr(REG_DST, 32'd50);
    reg_wr(REG_CTRL, 32'h1);
    finish_copy();
    model_copy(0, 112, 16);
    verify_range(112, 16);
    verify_range(50, 2);

    // Source words differ from what the destination already holds
    start_copy(20, 120, 0);
    finish_copy();
    verify_range(120, 3);

    assert_fails = UUT.asserts_i.fail_count;
    $display("Closing report: %0d value errors, %0d assertion failures",
             err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- flist.f
logic/memcopy_pkg.sv
logic/memcopy_regs.sv
logic/memcopy_reader.sv
logic/credit_fifo.sv
logic/memcopy_writer.sv
logic/slow_memory.sv
logic/testharness_ext.sv
sim/testharness_ext_asserts.sv
sim/tb_testharness_ext.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory-copy harness testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_testharness_ext \
  -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
